// File: rename_pkg.sv
`default_nettype none

package rename_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    // Architectural and physical register counts
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 38;

    // Tags left over once every arch reg is mapped
    localparam int FREE_REGS = PHYS_REGS - ARCH_REGS;

    // Reorder buffer entries
    localparam int ROB_DEPTH = 8;

    // Pointer and counter widths for the queues
    localparam int FL_PTR_W  = $clog2(FREE_REGS);
    localparam int FL_CNT_W  = $clog2(FREE_REGS + 1);
    localparam int ROB_CNT_W = $clog2(ROB_DEPTH + 1);

    ////////////////////////////////////////
    // Tag types
    ////////////////////////////////////////

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;

    ////////////////////////////////////////
    // Shared packets
    ////////////////////////////////////////

    // Incoming instruction at dispatch
    typedef struct packed {
        logic      rd_wen;
        arch_reg_t rd_arch;
        arch_reg_t rs1_arch;
        arch_reg_t rs2_arch;
    } disp_req_t;

    // Rename result, one cycle after acceptance
    typedef struct packed {
        logic      valid;
        rob_idx_t  rob_idx;
        phys_reg_t rd_new_phys;
        phys_reg_t rd_old_phys;
        phys_reg_t rs1_phys;
        logic      rs1_ready;
        phys_reg_t rs2_phys;
        logic      rs2_ready;
    } rename_rsp_t;

    // Completion pulse by ROB slot
    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
    } complete_t;

    // Payload held per ROB slot
    typedef struct packed {
        logic      rd_wen;
        arch_reg_t rd_arch;
        phys_reg_t rd_new_phys;
        phys_reg_t rd_old_phys;
    } rob_entry_t;

    // Retired instruction
    typedef struct packed {
        logic      valid;
        logic      rd_wen;
        arch_reg_t rd_arch;
        phys_reg_t rd_new_phys;
        phys_reg_t rd_old_phys;
    } commit_t;

    // Tag message, wakeup or release
    typedef struct packed {
        logic      valid;
        phys_reg_t phys;
    } phys_msg_t;

endpackage

`default_nettype wire

// File: map_table.sv
`timescale 1ns/10ps
`default_nettype none

module map_table import rename_pkg::*; (
    input  logic      clock,
    input  logic      reset,

    // Source and destination lookups
    input  arch_reg_t rs1_arch_i,
    input  arch_reg_t rs2_arch_i,
    input  arch_reg_t rd_arch_i,

    // Destination rename
    input  logic      rename_we_i,
    input  phys_reg_t new_phys_i,

    // Completion wakeup
    input  phys_msg_t wakeup_i,

    output phys_reg_t rs1_phys_o,
    output logic      rs1_ready_o,
    output phys_reg_t rs2_phys_o,
    output logic      rs2_ready_o,
    output phys_reg_t old_phys_o
);

    // Speculative arch to phys map
    phys_reg_t              map_q [ARCH_REGS];

    // One ready bit per physical tag
    logic [PHYS_REGS-1:0]   ready_q;

    ////////////////////////////////////////
    // Lookups
    ////////////////////////////////////////

    // Reads see state from before this edge
    assign rs1_phys_o  = map_q[rs1_arch_i];
    assign rs2_phys_o  = map_q[rs2_arch_i];
    assign rs1_ready_o = ready_q[map_q[rs1_arch_i]];
    assign rs2_ready_o = ready_q[map_q[rs2_arch_i]];

    // Previous mapping of the destination
    assign old_phys_o  = map_q[rd_arch_i];

    ////////////////////////////////////////
    // Update
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // Identity map, everything ready
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= phys_reg_t'(i);
            end
            ready_q <= '1;
        end else begin
            // Completing tag becomes ready
            if (wakeup_i.valid) begin
                ready_q[wakeup_i.phys] <= 1'b1;
            end
            // New tag pending until its producer completes
            if (rename_we_i) begin
                map_q[rd_arch_i]    <= new_phys_i;
                ready_q[new_phys_i] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: free_list.sv
`timescale 1ns/10ps
`default_nettype none

module free_list import rename_pkg::*; (
    input  logic      clock,
    input  logic      reset,

    // Pop the oldest free tag
    input  logic      alloc_i,

    // Old tag coming back at retire
    input  phys_msg_t release_i,

    output phys_reg_t alloc_phys_o,
    output logic      empty_o
);

    // Tag storage and queue state
    phys_reg_t           fifo_q [FREE_REGS];
    logic [FL_PTR_W-1:0] head_q;
    logic [FL_PTR_W-1:0] tail_q;
    logic [FL_CNT_W-1:0] count_q;

    logic                push;
    logic                pop;

    // Wrap at the list depth, not a power of two
    function automatic logic [FL_PTR_W-1:0] next_ptr(input logic [FL_PTR_W-1:0] ptr);
        if (ptr == FL_PTR_W'(FREE_REGS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Head of the queue goes out directly
    assign alloc_phys_o = fifo_q[head_q];
    assign empty_o      = (count_q == '0);

    assign push = release_i.valid;
    assign pop  = alloc_i;

    always_ff @(posedge clock) begin
        if (reset) begin
            // Preload the tags past the arch range
            for (int i = 0; i < FREE_REGS; i++) begin
                fifo_q[i] <= phys_reg_t'(ARCH_REGS + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= FL_CNT_W'(FREE_REGS);
        end else begin
            if (push) begin
                fifo_q[tail_q] <= release_i.phys;
                tail_q         <= next_ptr(tail_q);
            end
            if (pop) begin
                head_q <= next_ptr(head_q);
            end
            // Same-cycle pop and push leave the count alone
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rob.sv
`timescale 1ns/10ps
`default_nettype none

module rob import rename_pkg::*; (
    input  logic       clock,
    input  logic       reset,

    // Dispatch side
    input  logic       push_i,
    input  rob_entry_t entry_i,

    // Completion by slot
    input  complete_t  complete_i,

    output rob_idx_t   tail_idx_o,
    output logic       full_o,
    output phys_msg_t  wakeup_o,
    output phys_msg_t  release_o,
    output commit_t    commit_o
);

    // Slot payloads and completion flags
    rob_entry_t           entries_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;

    // Circular pointers, wrap for free at 8
    rob_idx_t             head_q;
    rob_idx_t             tail_q;
    logic [ROB_CNT_W-1:0] count_q;

    logic                 retire;
    rob_entry_t           head_entry;
    rob_entry_t           cmpl_entry;

    assign tail_idx_o = tail_q;
    assign full_o     = (count_q == ROB_CNT_W'(ROB_DEPTH));

    assign head_entry = entries_q[head_q];
    assign cmpl_entry = entries_q[complete_i.rob_idx];

    ////////////////////////////////////////
    // Wakeup and release
    ////////////////////////////////////////

    // Wakeup straight from the completion port
    assign wakeup_o.valid = complete_i.valid && cmpl_entry.rd_wen;
    assign wakeup_o.phys  = cmpl_entry.rd_new_phys;

    // Oldest entry leaves once done
    assign retire = (count_q != '0) && done_q[head_q];

    // Displaced tag back to the free list
    assign release_o.valid = retire && head_entry.rd_wen;
    assign release_o.phys  = head_entry.rd_old_phys;

    ////////////////////////////////////////
    // Slot storage
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (push_i) begin
            entries_q[tail_q] <= entry_i;
        end
    end

    ////////////////////////////////////////
    // Pointers, flags and commit
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            done_q         <= '0;
            head_q         <= '0;
            tail_q         <= '0;
            count_q        <= '0;
            commit_o.valid <= 1'b0;
        end else begin
            if (retire) begin
                done_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;
            end
            // New slot starts not done
            if (push_i) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (complete_i.valid) begin
                done_q[complete_i.rob_idx] <= 1'b1;
            end
            if (push_i && !retire) begin
                count_q <= count_q + 1'b1;
            end else if (retire && !push_i) begin
                count_q <= count_q - 1'b1;
            end
            // Registered view of the retiring entry
            commit_o.valid       <= retire;
            commit_o.rd_wen      <= head_entry.rd_wen;
            commit_o.rd_arch     <= head_entry.rd_arch;
            commit_o.rd_new_phys <= head_entry.rd_new_phys;
            commit_o.rd_old_phys <= head_entry.rd_old_phys;
        end
    end

endmodule

`default_nettype wire

// File: rename_stage.sv
`timescale 1ns/10ps
`default_nettype none

module rename_stage import rename_pkg::*; (
    input  logic        clock,
    input  logic        reset,

    // Dispatch handshake
    input  logic        disp_valid_i,
    input  disp_req_t   disp_req_i,
    output logic        disp_ready_o,

    // Resource state
    input  logic        rob_full_i,
    input  logic        free_empty_i,
    input  phys_reg_t   alloc_phys_i,
    input  rob_idx_t    tail_idx_i,

    // Map table reads
    input  phys_reg_t   rs1_phys_i,
    input  logic        rs1_ready_i,
    input  phys_reg_t   rs2_phys_i,
    input  logic        rs2_ready_i,
    input  phys_reg_t   old_phys_i,

    output logic        alloc_o,
    output logic        rob_push_o,
    output rob_entry_t  rob_entry_o,
    output rename_rsp_t rename_o
);

    logic      accept;
    phys_reg_t new_tag;
    phys_reg_t old_tag;

    // Stall on a full ROB or empty free list, even without a destination
    assign disp_ready_o = !rob_full_i && !free_empty_i;
    assign accept       = disp_valid_i && disp_ready_o;

    // Only destination writers take a tag
    assign alloc_o    = accept && disp_req_i.rd_wen;
    assign rob_push_o = accept;

    // No destination, report zero tags
    assign new_tag = disp_req_i.rd_wen ? alloc_phys_i : '0;
    assign old_tag = disp_req_i.rd_wen ? old_phys_i : '0;

    assign rob_entry_o.rd_wen      = disp_req_i.rd_wen;
    assign rob_entry_o.rd_arch     = disp_req_i.rd_arch;
    assign rob_entry_o.rd_new_phys = new_tag;
    assign rob_entry_o.rd_old_phys = old_tag;

    ////////////////////////////////////////
    // Rename result register
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            rename_o.valid <= 1'b0;
        end else begin
            // One-cycle pulse per acceptance
            rename_o.valid       <= accept;
            rename_o.rob_idx     <= tail_idx_i;
            rename_o.rd_new_phys <= new_tag;
            rename_o.rd_old_phys <= old_tag;
            rename_o.rs1_phys    <= rs1_phys_i;
            rename_o.rs1_ready   <= rs1_ready_i;
            rename_o.rs2_phys    <= rs2_phys_i;
            rename_o.rs2_ready   <= rs2_ready_i;
        end
    end

endmodule

`default_nettype wire

// File: rename_core.sv
`timescale 1ns/10ps
`default_nettype none

module rename_core import rename_pkg::*; (
    input  logic        clock,
    input  logic        reset,

    input  logic        disp_valid_i,
    input  disp_req_t   disp_req_i,
    output logic        disp_ready_o,

    input  complete_t   complete_i,

    output rename_rsp_t rename_o,
    output commit_t     commit_o
);

    ////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////

    // Rename stage requests
    logic       alloc;
    logic       rob_push;
    rob_entry_t rob_entry;

    // Free list state
    phys_reg_t  alloc_phys;
    logic       free_empty;

    // ROB state and tag traffic
    rob_idx_t   tail_idx;
    logic       rob_full;
    phys_msg_t  wakeup;
    phys_msg_t  release_msg;

    // Map table reads
    phys_reg_t  rs1_phys;
    logic       rs1_ready;
    phys_reg_t  rs2_phys;
    logic       rs2_ready;
    phys_reg_t  old_phys;

    rename_stage u_rename_stage (
        .clock        (clock),
        .reset        (reset),
        .disp_valid_i (disp_valid_i),
        .disp_req_i   (disp_req_i),
        .disp_ready_o (disp_ready_o),
        .rob_full_i   (rob_full),
        .free_empty_i (free_empty),
        .alloc_phys_i (alloc_phys),
        .tail_idx_i   (tail_idx),
        .rs1_phys_i   (rs1_phys),
        .rs1_ready_i  (rs1_ready),
        .rs2_phys_i   (rs2_phys),
        .rs2_ready_i  (rs2_ready),
        .old_phys_i   (old_phys),
        .alloc_o      (alloc),
        .rob_push_o   (rob_push),
        .rob_entry_o  (rob_entry),
        .rename_o     (rename_o)
    );

    // Allocation doubles as the map write enable
    map_table u_map_table (
        .clock       (clock),
        .reset       (reset),
        .rs1_arch_i  (disp_req_i.rs1_arch),
        .rs2_arch_i  (disp_req_i.rs2_arch),
        .rd_arch_i   (disp_req_i.rd_arch),
        .rename_we_i (alloc),
        .new_phys_i  (alloc_phys),
        .wakeup_i    (wakeup),
        .rs1_phys_o  (rs1_phys),
        .rs1_ready_o (rs1_ready),
        .rs2_phys_o  (rs2_phys),
        .rs2_ready_o (rs2_ready),
        .old_phys_o  (old_phys)
    );

    free_list u_free_list (
        .clock        (clock),
        .reset        (reset),
        .alloc_i      (alloc),
        .release_i    (release_msg),
        .alloc_phys_o (alloc_phys),
        .empty_o      (free_empty)
    );

    rob u_rob (
        .clock      (clock),
        .reset      (reset),
        .push_i     (rob_push),
        .entry_i    (rob_entry),
        .complete_i (complete_i),
        .tail_idx_o (tail_idx),
        .full_o     (rob_full),
        .wakeup_o   (wakeup),
        .release_o  (release_msg),
        .commit_o   (commit_o)
    );

endmodule

`default_nettype wire

// File: tb_rename_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rename_core import rename_pkg::*; ();

    // First-cycle ready expectation per row
    localparam int RDY_LO  = 0;
    localparam int RDY_HI  = 1;
    localparam int RDY_ANY = 2;
    localparam int RANDOM_ROWS = 40;

    // One stimulus row
    typedef struct packed {
        logic       disp_valid;
        disp_req_t  req;
        logic       cmp_valid;
        logic       cmp_any;      // any pending slot, chosen at run time
        rob_idx_t   cmp_idx;
        logic [1:0] exp_ready;
    } row_t;

    logic        clock;
    logic        reset;
    logic        disp_valid_i;
    disp_req_t   disp_req_i;
    logic        disp_ready_o;
    complete_t   complete_i;
    rename_rsp_t rename_o;
    commit_t     commit_o;

    // Reference model state
    phys_reg_t            m_map [ARCH_REGS];
    logic [PHYS_REGS-1:0] m_rdy;
    phys_reg_t            m_free [$];
    rob_entry_t           m_rob [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] m_done;
    int                   m_head;
    int                   m_tail;
    int                   m_count;
    rename_rsp_t          exp_ren;
    commit_t              exp_com;

    row_t                 rows [$];
    logic                 table_built;
    int                   seed;

    rename_core dut_i (
        .clock        (clock),
        .reset        (reset),
        .disp_valid_i (disp_valid_i),
        .disp_req_i   (disp_req_i),
        .disp_ready_o (disp_ready_o),
        .complete_i   (complete_i),
        .rename_o     (rename_o),
        .commit_o     (commit_o)
    );

    // 40 ns clock
    always #20 clock = ~clock;

    ////////////////////////////////////////
    // Checking
    ////////////////////////////////////////

    task automatic abort(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare(input string what, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            abort($sformatf("error at %0d ns: %s is 0x%0h, expected 0x%0h",
                            $time, what, actual, expected));
        end
    endtask

    // Outputs registered at the last rising edge
    task automatic check_outputs();
        compare("rename_o.valid", 32'(rename_o.valid), 32'(exp_ren.valid));
        if (exp_ren.valid) begin
            compare("rename_o.rob_idx", 32'(rename_o.rob_idx), 32'(exp_ren.rob_idx));
            compare("rename_o.rd_new_phys", 32'(rename_o.rd_new_phys), 32'(exp_ren.rd_new_phys));
            compare("rename_o.rd_old_phys", 32'(rename_o.rd_old_phys), 32'(exp_ren.rd_old_phys));
            compare("rename_o.rs1_phys", 32'(rename_o.rs1_phys), 32'(exp_ren.rs1_phys));
            compare("rename_o.rs1_ready", 32'(rename_o.rs1_ready), 32'(exp_ren.rs1_ready));
            compare("rename_o.rs2_phys", 32'(rename_o.rs2_phys), 32'(exp_ren.rs2_phys));
            compare("rename_o.rs2_ready", 32'(rename_o.rs2_ready), 32'(exp_ren.rs2_ready));
        end
        compare("commit_o.valid", 32'(commit_o.valid), 32'(exp_com.valid));
        if (exp_com.valid) begin
            compare("commit_o.rd_wen", 32'(commit_o.rd_wen), 32'(exp_com.rd_wen));
            compare("commit_o.rd_arch", 32'(commit_o.rd_arch), 32'(exp_com.rd_arch));
            compare("commit_o.rd_new_phys", 32'(commit_o.rd_new_phys), 32'(exp_com.rd_new_phys));
            compare("commit_o.rd_old_phys", 32'(commit_o.rd_old_phys), 32'(exp_com.rd_old_phys));
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    task automatic reset_model();
        // Identity map, all ready, spare tags queued in order
        for (int i = 0; i < ARCH_REGS; i++) begin
            m_map[i] = phys_reg_t'(i);
        end
        m_rdy = '1;
        m_free.delete();
        for (int i = ARCH_REGS; i < PHYS_REGS; i++) begin
            m_free.push_back(phys_reg_t'(i));
        end
        m_done  = '0;
        m_head  = 0;
        m_tail  = 0;
        m_count = 0;
        exp_ren = '0;
        exp_com = '0;
    endtask

    function automatic logic ready_expected();
        return (m_count < ROB_DEPTH) && (m_free.size() > 0);
    endfunction

    // In flight and not yet completed
    function automatic logic is_pending(input int idx);
        int age;
        age = (idx - m_head + ROB_DEPTH) % ROB_DEPTH;
        return (age < m_count) && !m_done[idx];
    endfunction

    function automatic int pick_pending();
        int cands [$];
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (is_pending(i)) begin
                cands.push_back(i);
            end
        end
        if (cands.size() == 0) begin
            return -1;
        end
        return cands[$unsigned($random(seed)) % cands.size()];
    endfunction

    // One rising edge of the model
    task automatic advance_model(input logic dv, input disp_req_t req, input complete_t cmp);
        logic       acc;
        logic       ret;
        rob_entry_t head;
        rob_entry_t ent;
        acc  = dv && ready_expected();
        ret  = (m_count > 0) && m_done[m_head];
        head = m_rob[m_head];
        // Lookups use the state from before the edge
        ent.rd_wen  = req.rd_wen;
        ent.rd_arch = req.rd_arch;
        if (req.rd_wen && m_free.size() > 0) begin
            ent.rd_new_phys = m_free[0];
            ent.rd_old_phys = m_map[req.rd_arch];
        end else begin
            ent.rd_new_phys = '0;
            ent.rd_old_phys = '0;
        end
        exp_ren             = '0;
        exp_ren.valid       = acc;
        exp_ren.rob_idx     = rob_idx_t'(m_tail);
        exp_ren.rd_new_phys = ent.rd_new_phys;
        exp_ren.rd_old_phys = ent.rd_old_phys;
        exp_ren.rs1_phys    = m_map[req.rs1_arch];
        exp_ren.rs1_ready   = m_rdy[m_map[req.rs1_arch]];
        exp_ren.rs2_phys    = m_map[req.rs2_arch];
        exp_ren.rs2_ready   = m_rdy[m_map[req.rs2_arch]];
        exp_com             = '0;
        exp_com.valid       = ret;
        exp_com.rd_wen      = head.rd_wen;
        exp_com.rd_arch     = head.rd_arch;
        exp_com.rd_new_phys = head.rd_new_phys;
        exp_com.rd_old_phys = head.rd_old_phys;
        // Completion marks the slot and wakes its tag
        if (cmp.valid) begin
            m_done[cmp.rob_idx] = 1'b1;
            if (m_rob[cmp.rob_idx].rd_wen) begin
                m_rdy[m_rob[cmp.rob_idx].rd_new_phys] = 1'b1;
            end
        end
        if (ret) begin
            m_done[m_head] = 1'b0;
            m_head         = (m_head + 1) % ROB_DEPTH;
            m_count        = m_count - 1;
        end
        if (acc) begin
            if (req.rd_wen) begin
                void'(m_free.pop_front());
                m_map[req.rd_arch]     = ent.rd_new_phys;
                m_rdy[ent.rd_new_phys] = 1'b0;
            end
            m_rob[m_tail]  = ent;
            m_done[m_tail] = 1'b0;
            m_tail         = (m_tail + 1) % ROB_DEPTH;
            m_count        = m_count + 1;
        end
        // Displaced tag rejoins at the back
        if (ret && head.rd_wen) begin
            m_free.push_back(head.rd_old_phys);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic add_row(input int dv, input int wen, input int rd, input int rs1,
                           input int rs2, input int cv, input int cidx, input int er);
        row_t r;
        r.disp_valid   = (dv != 0);
        r.req.rd_wen   = (wen != 0);
        r.req.rd_arch  = arch_reg_t'(rd);
        r.req.rs1_arch = arch_reg_t'(rs1);
        r.req.rs2_arch = arch_reg_t'(rs2);
        r.cmp_valid    = (cv != 0);
        r.cmp_any      = 1'b0;
        r.cmp_idx      = rob_idx_t'(cidx);
        r.exp_ready    = 2'(er);
        rows.push_back(r);
    endtask

    task automatic add_random_row();
        row_t r;
        r.disp_valid   = ($unsigned($random(seed)) % 8) != 0;
        r.req.rd_wen   = ($unsigned($random(seed)) % 4) != 0;
        r.req.rd_arch  = arch_reg_t'($unsigned($random(seed)));
        r.req.rs1_arch = arch_reg_t'($unsigned($random(seed)));
        r.req.rs2_arch = arch_reg_t'($unsigned($random(seed)));
        r.cmp_valid    = ($unsigned($random(seed)) % 2) != 0;
        r.cmp_any      = 1'b1;
        r.cmp_idx      = '0;
        r.exp_ready    = 2'(RDY_ANY);
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Fresh map, sources read their own numbers
        add_row(1, 1, 1, 2, 3, 0, 0, RDY_HI);
        // Reads tag 32 while still pending
        add_row(1, 1, 2, 1, 1, 0, 0, RDY_HI);
        add_row(1, 1, 1, 1, 2, 0, 0, RDY_HI);
        // Slot 2 completes at the same edge as a read of tag 34
        add_row(1, 1, 3, 1, 0, 1, 2, RDY_HI);
        // Tag 34 ready now, completions out of order
        add_row(1, 1, 4, 1, 3, 1, 0, RDY_HI);
        add_row(1, 1, 5, 4, 2, 1, 1, RDY_HI);
        // Released tags 1 then 2 come back
        add_row(1, 1, 6, 2, 0, 0, 0, RDY_HI);
        add_row(1, 1, 7, 0, 0, 0, 0, RDY_HI);
        add_row(1, 1, 8, 0, 0, 0, 0, RDY_HI);
        // Free list empty until slot 3 retires
        add_row(1, 1, 9, 8, 0, 1, 3, RDY_LO);
        // Drain everything
        add_row(0, 0, 0, 0, 0, 1, 4, RDY_ANY);
        add_row(0, 0, 0, 0, 0, 1, 5, RDY_ANY);
        add_row(0, 0, 0, 0, 0, 1, 6, RDY_ANY);
        add_row(0, 0, 0, 0, 0, 1, 7, RDY_ANY);
        add_row(0, 0, 0, 0, 0, 1, 0, RDY_ANY);
        add_row(0, 0, 0, 0, 0, 1, 1, RDY_ANY);
        add_row(0, 0, 0, 0, 0, 0, 0, RDY_ANY);
        // No destination, fills all eight slots
        for (int i = 0; i < ROB_DEPTH; i++) begin
            add_row(1, 0, 10, i, i + 1, 0, 0, RDY_HI);
        end
        // ROB full until the head retires
        add_row(1, 0, 10, 11, 12, 1, 2, RDY_LO);
        add_row(1, 1, 1, 1, 5, 1, 3, RDY_LO);
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            add_random_row();
        end
    endtask

    // Check, drive on the falling edge, step the model, wait one cycle
    task automatic run_cycle(input logic dv, input disp_req_t req, input complete_t cmp,
                             output logic accepted);
        check_outputs();
        compare("disp_ready_o", 32'(disp_ready_o), 32'(ready_expected()));
        accepted     = dv && ready_expected();
        disp_valid_i = dv;
        disp_req_i   = req;
        complete_i   = cmp;
        advance_model(dv, req, cmp);
        @(posedge clock);
        @(negedge clock);
    endtask

    initial begin
        logic      accepted;
        logic      first;
        logic      finished;
        complete_t cmp;
        int        pick;
        row_t      r;
        seed         = 56;
        table_built  = 1'b0;
        clock        = 1'b0;
        reset        = 1'b1;
        disp_valid_i = 1'b0;
        disp_req_i   = '0;
        complete_i   = '0;
        reset_model();
        build_table();
        table_built = 1'b1;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        // Idle outputs and open handshake
        compare("disp_ready_o after reset", 32'(disp_ready_o), 32'(1));
        check_outputs();
        foreach (rows[n]) begin
            r        = rows[n];
            first    = 1'b1;
            finished = 1'b0;
            // Dispatch repeats until accepted
            while (!finished) begin
                if (first && r.exp_ready != 2'(RDY_ANY)) begin
                    compare("disp_ready_o on first try", 32'(disp_ready_o),
                            32'(r.exp_ready[0]));
                end
                cmp = '0;
                if (r.cmp_any) begin
                    pick = pick_pending();
                    if ((!first || r.cmp_valid) && pick >= 0) begin
                        cmp.valid   = 1'b1;
                        cmp.rob_idx = rob_idx_t'(pick);
                    end
                end else if (first && r.cmp_valid) begin
                    if (!is_pending(int'(r.cmp_idx))) begin
                        abort($sformatf("row %0d completes ROB slot %0d, which is not in flight",
                                        n, r.cmp_idx));
                    end
                    cmp.valid   = 1'b1;
                    cmp.rob_idx = r.cmp_idx;
                end
                run_cycle(r.disp_valid, r.req, cmp, accepted);
                finished = !r.disp_valid || accepted;
                first    = 1'b0;
            end
        end
        // Complete the rest and let it retire
        while (m_count != 0) begin
            cmp  = '0;
            pick = pick_pending();
            if (pick >= 0) begin
                cmp.valid   = 1'b1;
                cmp.rob_idx = rob_idx_t'(pick);
            end
            run_cycle(1'b0, '0, cmp, accepted);
        end
        check_outputs();
        compare("disp_ready_o after drain", 32'(disp_ready_o), 32'(1));
        $display("TEST PASS");
        $finish;
    end

    // Watchdog, 20 cycles per row plus reset
    initial begin
        int limit;
        wait (table_built);
        limit = rows.size() * 20;
        repeat (limit + 8) @(posedge clock);
        abort($sformatf("watchdog expired after %0d cycles, the run did not finish", limit));
    end

endmodule

`default_nettype wire

// File: all.f
rename_pkg.sv
map_table.sv
free_list.sv
rob.sv
rename_stage.sv
rename_core.sv
tb_rename_core.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= tb_rename_core
RTL_TOP    ?= rename_core
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
